// File: bench/mini_mcu_assertions.sv
// OBI protocol checks on the master side of the system bus.
// Attached to every system_bus instance by the bind at the end.
`timescale 1ns/1ps

module mini_mcu_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic req0_i,
    input logic req1_i,
    input logic gnt0_i,
    input logic gnt1_i,
    input logic rvalid0_i,
    input logic rvalid1_i
);

  // any request gets exactly one grant, and only a requester is granted
  one_grant: assert property (@(posedge clk_i)
      !(gnt0_i && gnt1_i) && (!gnt0_i || req0_i) && (!gnt1_i || req1_i) &&
      ((req0_i || req1_i) == (gnt0_i || gnt1_i)))
    else $error("grants do not match the requests");

  rvalid_after_gnt0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt0_i |=> rvalid0_i)
    else $error("master 0 grant without rvalid one cycle later");

  rvalid_after_gnt1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt1_i |=> rvalid1_i)
    else $error("master 1 grant without rvalid one cycle later");

  quiet_in_reset: assert property (@(posedge clk_i)
      !rst_n_i |-> !(gnt0_i || gnt1_i || rvalid0_i || rvalid1_i))
    else $error("bus activity during reset");

endmodule

bind system_bus mini_mcu_assertions i_assertions (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req0_i   (masters_i[0].req),
    .req1_i   (masters_i[1].req),
    .gnt0_i   (masters_i[0].gnt),
    .gnt1_i   (masters_i[1].gnt),
    .rvalid0_i(masters_i[0].rvalid),
    .rvalid1_i(masters_i[1].rvalid)
);

// File: bench/tb_mini_mcu.sv
// Testbench for the mini MCU bus subsystem.
// Drives both OBI masters, keeps a shadow model and checks every response.
`timescale 1ns/1ps

module tb_mini_mcu;
  import mcu_pkg::*;

  localparam int N_WORDS = 24;
  localparam int N_BURST = 16;
  localparam int TOTAL_ACC = 4 * N_WORDS + 4 * N_WORDS + 3 * N_BURST + 16;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b0;
  logic m0_req_i, m0_we_i, m1_req_i, m1_we_i;
  logic [ADDR_W-1:0] m0_addr_i, m1_addr_i;
  be_t m0_be_i, m1_be_i;
  word_t m0_wdata_i, m1_wdata_i, m0_rdata_o, m1_rdata_o, exit_value_o;
  logic m0_gnt_o, m0_rvalid_o, m1_gnt_o, m1_rvalid_o, exit_valid_o;

  word_t shadow_ram [RAM_WORDS];
  word_t sh_exit_value, sh_scratch;
  logic sh_exit_valid;
  word_t exp0_q[$], exp1_q[$];
  logic rd0_q[$], rd1_q[$];
  int errors = 0;
  int checks = 0;
  int last_gnt;

  mini_mcu i_dut (.*);

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #((TOTAL_ACC * 20 + 200) * 10);
    $display("timeout: the run did not finish in the expected time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return r;
  endfunction

  // expected read word from the memory map and shadow state
  function automatic word_t ref_read(logic [ADDR_W-1:0] addr);
    if (addr[31:28] == REGION_RAM) return shadow_ram[addr[9:2]];
    if (addr[31:28] != REGION_CTRL) return 32'hBADACCE5;
    case (addr[3:2])
      2'd0: return sh_exit_value;
      2'd1: return {31'b0, sh_exit_valid};
      2'd2: return sh_scratch;
      default: return '0;
    endcase
  endfunction

  task automatic ref_write(logic [ADDR_W-1:0] addr, be_t be, word_t wdata);
    if (addr[31:28] == REGION_RAM) begin
      shadow_ram[addr[9:2]] = merge_bytes(shadow_ram[addr[9:2]], wdata, be);
    end else if (addr[31:28] == REGION_CTRL) begin
      case (addr[3:2])
        2'd0: sh_exit_value = merge_bytes(sh_exit_value, wdata, be);
        2'd1: sh_exit_valid = sh_exit_valid | wdata[0];
        2'd2: sh_scratch = merge_bytes(sh_scratch, wdata, be);
        default: ;
      endcase
    end
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_exit(word_t got_v, logic got_valid, word_t exp_v, logic exp_valid);
    checks++;
    if (got_v !== exp_v || got_valid !== exp_valid) begin
      $display("ERR %0t: exit pair %h/%b, expected %h/%b", $time, got_v, got_valid,
               exp_v, exp_valid);
      errors++;
    end
  endtask

  task automatic drive(int m, logic req, logic [ADDR_W-1:0] addr, logic we, be_t be,
                       word_t wdata);
    if (m == 0) begin
      m0_req_i = req;
      m0_addr_i = addr;
      m0_we_i = we;
      m0_be_i = be;
      m0_wdata_i = wdata;
    end else begin
      m1_req_i = req;
      m1_addr_i = addr;
      m1_we_i = we;
      m1_be_i = be;
      m1_wdata_i = wdata;
    end
  endtask

  // called at 1 ns after an edge, returns 1 ns after the grant edge with req low
  task automatic access(int m, logic [ADDR_W-1:0] addr, logic we, be_t be, word_t wdata);
    int n;
    logic g;
    n = 0;
    drive(m, 1'b1, addr, we, be, wdata);
    do begin
      @(negedge clk_i);
      g = (m == 0) ? m0_gnt_o : m1_gnt_o;
      n++;
    end while (!g && n < 20);
    if (!g) begin
      $display("master %0d got no grant for address %h", m, addr);
      errors++;
    end else begin
      if (we) ref_write(addr, be, wdata);
      if (m == 0) begin
        exp0_q.push_back(ref_read(addr));
        rd0_q.push_back(!we);
      end else begin
        exp1_q.push_back(ref_read(addr));
        rd1_q.push_back(!we);
      end
    end
    @(posedge clk_i);
    #1;
    drive(m, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic idle_and_drain();
    int n;
    drive(0, 1'b0, '0, 1'b0, '0, '0);
    drive(1, 1'b0, '0, 1'b0, '0, '0);
    n = 0;
    while ((exp0_q.size() != 0 || exp1_q.size() != 0) && n < 20) begin
      @(posedge clk_i);
      n++;
    end
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      $display("responses still missing after the last request");
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [ADDR_W-1:0] ram_addr(int idx);
    return {22'h0, 8'(idx), 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] ctrl_addr(logic [1:0] idx);
    return {4'h2, 24'h0, idx, 2'b00};
  endfunction

  // compares responses and watches the arbitration order
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      last_gnt = 1;
    end else begin
      if (m0_rvalid_o) begin
        if (exp0_q.size() == 0) begin
          $display("master 0 got an rvalid with no access outstanding");
          errors++;
        end else if (rd0_q.pop_front()) check_word("master 0", m0_rdata_o, exp0_q.pop_front());
        else void'(exp0_q.pop_front());
      end
      if (m1_rvalid_o) begin
        if (exp1_q.size() == 0) begin
          $display("master 1 got an rvalid with no access outstanding");
          errors++;
        end else if (rd1_q.pop_front()) check_word("master 1", m1_rdata_o, exp1_q.pop_front());
        else void'(exp1_q.pop_front());
      end
      if (m0_req_i && m1_req_i) begin
        checks++;
        if ((m0_gnt_o && last_gnt == 0) || (m1_gnt_o && last_gnt == 1)) begin
          $display("ERR %0t: contended grant went to the same master twice", $time);
          errors++;
        end
      end
      if (m0_gnt_o) last_gnt = 0;
      if (m1_gnt_o) last_gnt = 1;
    end
  end

  initial begin
    word_t d;
    void'($urandom(32'h6a919bdb));
    drive(0, 1'b0, '0, 1'b0, '0, '0);
    drive(1, 1'b0, '0, 1'b0, '0, '0);
    sh_exit_value = '0;
    sh_scratch = '0;
    sh_exit_valid = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    // 1: full words, each master reads the other's words
    fork
      for (int i = 0; i < N_WORDS; i++) access(0, ram_addr(i), 1'b1, 4'hf, $urandom);
      for (int i = 0; i < N_WORDS; i++) access(1, ram_addr(128 + i), 1'b1, 4'hf, $urandom);
    join
    fork
      for (int i = 0; i < N_WORDS; i++) access(0, ram_addr(128 + i), 1'b0, '0, '0);
      for (int i = 0; i < N_WORDS; i++) access(1, ram_addr(i), 1'b0, '0, '0);
    join
    idle_and_drain();
    $display("test 1 random words finished, %0d errors so far", errors);

    // 2: byte-enabled writes
    fork
      for (int i = 0; i < N_WORDS; i++) access(0, ram_addr(128 + i), 1'b1, be_t'($urandom),
                                               $urandom);
      for (int i = 0; i < N_WORDS; i++) access(1, ram_addr(i), 1'b1, be_t'($urandom), $urandom);
    join
    fork
      for (int i = 0; i < N_WORDS; i++) access(0, ram_addr(i), 1'b0, '0, '0);
      for (int i = 0; i < N_WORDS; i++) access(1, ram_addr(128 + i), 1'b0, '0, '0);
    join
    idle_and_drain();
    $display("test 2 partial writes finished, %0d errors so far", errors);

    // 3: both masters keep req high back to back
    fork
      for (int i = 0; i < N_BURST; i++) access(0, ram_addr($urandom_range(N_WORDS - 1)),
                                               1'b0, '0, '0);
      for (int i = 0; i < N_BURST; i++) begin
        access(1, ram_addr(128 + i), 1'b1, 4'hf, $urandom);
        access(1, ram_addr(128 + i), 1'b0, '0, '0);
      end
    join
    idle_and_drain();
    $display("test 3 contended bursts finished, %0d errors so far", errors);

    // 4: exit value and sticky exit valid
    d = $urandom;
    access(1, ctrl_addr(2'd0), 1'b1, 4'hf, d);
    check_exit(exit_value_o, exit_valid_o, sh_exit_value, sh_exit_valid);
    access(1, ctrl_addr(2'd1), 1'b1, 4'hf, 32'h1);
    check_exit(exit_value_o, exit_valid_o, sh_exit_value, sh_exit_valid);
    access(1, ctrl_addr(2'd1), 1'b1, 4'hf, 32'h0);
    check_exit(exit_value_o, exit_valid_o, d, 1'b1);
    access(0, ctrl_addr(2'd1), 1'b0, '0, '0);
    access(0, ctrl_addr(2'd0), 1'b0, '0, '0);
    idle_and_drain();
    $display("test 4 exit registers finished, %0d errors so far", errors);

    // 5: scratch, unused index, unmapped regions
    access(0, ctrl_addr(2'd2), 1'b1, 4'hf, $urandom);
    access(0, ctrl_addr(2'd2), 1'b0, '0, '0);
    access(1, ctrl_addr(2'd3), 1'b0, '0, '0);
    access(1, 32'h3000_0010, 1'b0, '0, '0);
    access(0, 32'h5000_0000, 1'b1, 4'hf, $urandom);
    access(0, ram_addr(0), 1'b0, '0, '0);
    idle_and_drain();
    $display("test 5 scratch and unmapped finished, %0d errors so far", errors);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the mini MCU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mini_mcu -f verilog.f

out=$(./obj_dir/Vtb_mini_mcu)
echo "$out"

echo "$out" | grep -q '\*\*\* TEST PASSED \*\*\*'

// File: source/mcu_pkg.sv
// Shared bus widths, memory map and register indices of the mini MCU.
// Imported by every RTL block and by the testbench.
package mcu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam int NUM_MASTERS = 2;
  localparam int MST_IDX_W = $clog2(NUM_MASTERS);

  // 1 KiB of word-addressed RAM
  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);

  localparam int REGION_W = 4;
  localparam int BYTE_OFF_W = 2;
  localparam int CTRL_IDX_W = 2;

  // address bits 31..28
  localparam logic [REGION_W-1:0] REGION_RAM = 4'h0;
  localparam logic [REGION_W-1:0] REGION_CTRL = 4'h2;

  localparam logic [CTRL_IDX_W-1:0] CTRL_EXIT_VALUE = 2'd0;
  localparam logic [CTRL_IDX_W-1:0] CTRL_EXIT_VALID = 2'd1;
  localparam logic [CTRL_IDX_W-1:0] CTRL_SCRATCH = 2'd2;

  localparam logic [DATA_W-1:0] UNMAPPED_DATA = 32'hBADACCE5;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [DATA_W/8-1:0] be_t;
  typedef logic [MST_IDX_W-1:0] mst_idx_t;

  // one bus address, seen either as a RAM word or as a control register
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [ADDR_W-REGION_W-RAM_IDX_W-BYTE_OFF_W-1:0] unused;
      logic [RAM_IDX_W-1:0] word_idx;
      logic [BYTE_OFF_W-1:0] byte_off;
    } ram;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [ADDR_W-REGION_W-CTRL_IDX_W-BYTE_OFF_W-1:0] unused;
      logic [CTRL_IDX_W-1:0] reg_idx;
      logic [BYTE_OFF_W-1:0] byte_off;
    } ctrl;
  } mcu_addr_u;

  // merge the enabled bytes of new_w into old_w
  function automatic word_t apply_be(word_t old_w, word_t new_w, be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < DATA_W / 8; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: source/mini_mcu.sv
// Top level of the mini MCU bus subsystem.
// Two OBI masters come in as plain ports and share RAM and the control block.
`timescale 1ns/1ps

module mini_mcu (
    input logic clk_i,
    input logic rst_n_i,

    // master 0, instruction side
    input  logic                       m0_req_i,
    input  logic [mcu_pkg::ADDR_W-1:0] m0_addr_i,
    input  logic                       m0_we_i,
    input  mcu_pkg::be_t               m0_be_i,
    input  mcu_pkg::word_t             m0_wdata_i,
    output logic                       m0_gnt_o,
    output logic                       m0_rvalid_o,
    output mcu_pkg::word_t             m0_rdata_o,

    // master 1, data side
    input  logic                       m1_req_i,
    input  logic [mcu_pkg::ADDR_W-1:0] m1_addr_i,
    input  logic                       m1_we_i,
    input  mcu_pkg::be_t               m1_be_i,
    input  mcu_pkg::word_t             m1_wdata_i,
    output logic                       m1_gnt_o,
    output logic                       m1_rvalid_o,
    output mcu_pkg::word_t             m1_rdata_o,

    output mcu_pkg::word_t exit_value_o,
    output logic           exit_valid_o
);

  import mcu_pkg::*;

  obi_if master_bus [NUM_MASTERS] ();
  obi_if ram_bus ();
  obi_if ctrl_bus ();

  assign master_bus[0].req   = m0_req_i;
  assign master_bus[0].addr  = m0_addr_i;
  assign master_bus[0].we    = m0_we_i;
  assign master_bus[0].be    = m0_be_i;
  assign master_bus[0].wdata = m0_wdata_i;

  assign m0_gnt_o    = master_bus[0].gnt;
  assign m0_rvalid_o = master_bus[0].rvalid;
  assign m0_rdata_o  = master_bus[0].rdata;

  assign master_bus[1].req   = m1_req_i;
  assign master_bus[1].addr  = m1_addr_i;
  assign master_bus[1].we    = m1_we_i;
  assign master_bus[1].be    = m1_be_i;
  assign master_bus[1].wdata = m1_wdata_i;

  assign m1_gnt_o    = master_bus[1].gnt;
  assign m1_rvalid_o = master_bus[1].rvalid;
  assign m1_rdata_o  = master_bus[1].rdata;

  system_bus i_system_bus (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .masters_i(master_bus),
      .ram_o    (ram_bus),
      .ctrl_o   (ctrl_bus)
  );

  ram_bank i_ram_bank (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .bus_i  (ram_bus)
  );

  soc_ctrl i_soc_ctrl (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .bus_i       (ctrl_bus),
      .exit_value_o(exit_value_o),
      .exit_valid_o(exit_valid_o)
  );

endmodule

// File: source/obi_arbiter.sv
// Round-robin arbiter that puts the OBI master ports onto one shared bus.
// Responses are steered back to the master granted in the previous cycle.
`timescale 1ns/1ps

module obi_arbiter (
    input logic clk_i,
    input logic rst_n_i,

    obi_if.slave  masters_i [mcu_pkg::NUM_MASTERS],
    obi_if.master bus_o
);

  import mcu_pkg::*;

  logic [NUM_MASTERS-1:0] req_vec;
  logic [NUM_MASTERS-1:0] we_vec;
  logic [ADDR_W-1:0]      addr_vec  [NUM_MASTERS];
  be_t                    be_vec    [NUM_MASTERS];
  word_t                  wdata_vec [NUM_MASTERS];

  mst_idx_t sel;
  mst_idx_t last_q;
  logic     bus_fire;

  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
    assign req_vec[i]   = masters_i[i].req;
    assign we_vec[i]    = masters_i[i].we;
    assign addr_vec[i]  = masters_i[i].addr;
    assign be_vec[i]    = masters_i[i].be;
    assign wdata_vec[i] = masters_i[i].wdata;

    assign masters_i[i].gnt    = bus_fire && (sel == mst_idx_t'(i));
    // last_q still names the master granted one cycle ago
    assign masters_i[i].rvalid = bus_o.rvalid && (last_q == mst_idx_t'(i));
    assign masters_i[i].rdata  = bus_o.rdata;
  end

  // search starts just after the last winner, last_q itself comes last
  always_comb begin
    int cand;
    sel = last_q;
    for (int k = NUM_MASTERS; k >= 1; k--) begin
      cand = (int'(last_q) + k) % NUM_MASTERS;
      if (req_vec[cand]) begin
        sel = mst_idx_t'(cand);
      end
    end
  end

  assign bus_o.req   = |req_vec;
  assign bus_o.addr  = addr_vec[sel];
  assign bus_o.we    = we_vec[sel];
  assign bus_o.be    = be_vec[sel];
  assign bus_o.wdata = wdata_vec[sel];

  assign bus_fire = bus_o.req && bus_o.gnt;

  // master 0 wins the first contended cycle after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= mst_idx_t'(NUM_MASTERS - 1);
    end else if (bus_fire) begin
      last_q <= sel;
    end
  end

endmodule

// File: source/obi_if.sv
// OBI request/response bundle between a bus master and a slave.
// The master modport issues requests, the slave modport answers them.
`timescale 1ns/1ps

interface obi_if;
  import mcu_pkg::*;

  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] addr;
  logic              we;
  be_t               be;
  word_t             wdata;
  logic              rvalid;
  word_t             rdata;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// File: source/ram_bank.sv
// On-chip RAM bank on an OBI slave port.
// Never stalls, answers every granted request one cycle later.
`timescale 1ns/1ps

module ram_bank (
    input logic clk_i,
    input logic rst_n_i,

    obi_if.slave bus_i
);

  import mcu_pkg::*;

  word_t mem [RAM_WORDS];

  mcu_addr_u            addr_view;
  logic [RAM_IDX_W-1:0] word_idx;
  logic                 wr_en;
  logic                 rd_en;

  word_t rdata_q;
  logic  rvalid_q;

  assign addr_view.raw = bus_i.addr;
  assign word_idx      = addr_view.ram.word_idx;

  assign bus_i.gnt = bus_i.req;

  assign wr_en = bus_i.req && bus_i.we;
  assign rd_en = bus_i.req && !bus_i.we;

  // storage and read port
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[word_idx] <= apply_be(mem[word_idx], bus_i.wdata, bus_i.be);
    end
    if (rd_en) begin
      rdata_q <= mem[word_idx];
    end
  end

  // one response per granted request, writes included
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

endmodule

// File: source/soc_ctrl.sv
// SoC control block with exit value, sticky exit valid and a scratch word.
// Registers are written at the grant edge and read back one cycle later.
`timescale 1ns/1ps

module soc_ctrl (
    input logic clk_i,
    input logic rst_n_i,

    obi_if.slave bus_i,

    output mcu_pkg::word_t exit_value_o,
    output logic           exit_valid_o
);

  import mcu_pkg::*;

  mcu_addr_u             addr_view;
  logic [CTRL_IDX_W-1:0] reg_idx;
  logic                  wr_en;

  word_t exit_value_q;
  word_t scratch_q;
  logic  exit_valid_q;
  logic  rvalid_q;
  word_t rdata_q;

  assign addr_view.raw = bus_i.addr;
  assign reg_idx       = addr_view.ctrl.reg_idx;

  assign bus_i.gnt = bus_i.req;
  assign wr_en     = bus_i.req && bus_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      scratch_q    <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      if (wr_en) begin
        case (reg_idx)
          CTRL_EXIT_VALUE: exit_value_q <= apply_be(exit_value_q, bus_i.wdata, bus_i.be);
          CTRL_SCRATCH:    scratch_q <= apply_be(scratch_q, bus_i.wdata, bus_i.be);
          // sticky until reset
          CTRL_EXIT_VALID: exit_valid_q <= exit_valid_q | bus_i.wdata[0];
          default:         ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req && !bus_i.we) begin
      case (reg_idx)
        CTRL_EXIT_VALUE: rdata_q <= exit_value_q;
        CTRL_EXIT_VALID: rdata_q <= {{(DATA_W-1){1'b0}}, exit_valid_q};
        CTRL_SCRATCH:    rdata_q <= scratch_q;
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// File: source/system_bus.sv
// Shared system bus: arbitrates the masters, decodes the address region
// and routes each request to the RAM, the control block or the error slave.
`timescale 1ns/1ps

module system_bus (
    input logic clk_i,
    input logic rst_n_i,

    obi_if.slave  masters_i [mcu_pkg::NUM_MASTERS],
    obi_if.master ram_o,
    obi_if.master ctrl_o
);

  import mcu_pkg::*;

  obi_if arb_bus ();

  mcu_addr_u addr_view;
  logic      is_ram;
  logic      is_ctrl;
  logic      is_unmapped;
  logic      bus_fire;

  // destination of the access granted last cycle
  logic ram_q;
  logic ctrl_q;
  logic unmapped_q;

  obi_arbiter i_arbiter (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .masters_i(masters_i),
      .bus_o    (arb_bus)
  );

  assign addr_view.raw = arb_bus.addr;

  assign is_ram      = (addr_view.ram.region == REGION_RAM);
  assign is_ctrl     = (addr_view.ctrl.region == REGION_CTRL);
  assign is_unmapped = !is_ram && !is_ctrl;

  // request steering, payload goes to both slaves
  assign ram_o.req   = arb_bus.req && is_ram;
  assign ram_o.addr  = arb_bus.addr;
  assign ram_o.we    = arb_bus.we;
  assign ram_o.be    = arb_bus.be;
  assign ram_o.wdata = arb_bus.wdata;

  assign ctrl_o.req   = arb_bus.req && is_ctrl;
  assign ctrl_o.addr  = arb_bus.addr;
  assign ctrl_o.we    = arb_bus.we;
  assign ctrl_o.be    = arb_bus.be;
  assign ctrl_o.wdata = arb_bus.wdata;

  // unmapped accesses are accepted here at once
  assign arb_bus.gnt = is_ram  ? ram_o.gnt :
                       is_ctrl ? ctrl_o.gnt :
                                 arb_bus.req;

  assign bus_fire = arb_bus.req && arb_bus.gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ram_q      <= 1'b0;
      ctrl_q     <= 1'b0;
      unmapped_q <= 1'b0;
    end else begin
      ram_q      <= bus_fire && is_ram;
      ctrl_q     <= bus_fire && is_ctrl;
      unmapped_q <= bus_fire && is_unmapped;
    end
  end

  // response side
  assign arb_bus.rvalid = (ram_q && ram_o.rvalid) ||
                          (ctrl_q && ctrl_o.rvalid) ||
                          unmapped_q;

  assign arb_bus.rdata = ram_q  ? ram_o.rdata :
                         ctrl_q ? ctrl_o.rdata :
                                  UNMAPPED_DATA;

endmodule

// File: verilog.f
source/mcu_pkg.sv
source/obi_if.sv
source/obi_arbiter.sv
source/system_bus.sv
source/ram_bank.sv
source/soc_ctrl.sv
source/mini_mcu.sv
bench/mini_mcu_assertions.sv
bench/tb_mini_mcu.sv
